// ==== source/readbackPkg.sv ====
package readbackPkg;

	// Transfer formats selectable by the CPU
	typedef enum logic [1:0]
	{
		FMT_GREY4 = 2'd0,
		FMT_GREY8 = 2'd1,
		FMT_RGB24 = 2'd2,
		FMT_RGB15 = 2'd3
	} pixFormat_t;

	// Control register, format in bits 2:1 and mask bit in bit 0
	typedef struct packed
	{
		pixFormat_t format;
		logic       setMask;
	} ctrlReg_t;

	localparam int WORD_W = 32;

	// FIFO sizing
	localparam int FIFO_DEPTH       = 16;
	localparam int FIFO_CNT_W       = 5;
	localparam int FIFO_STOP_MARGIN = 3;

	// Register map, byte addresses
	localparam int ADDR_W = 4;
	localparam logic [ADDR_W-1:0] ADDR_CTRL   = 4'h0;
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 4'h4;
	localparam logic [ADDR_W-1:0] ADDR_DATA   = 4'h8;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== source/fifoWriteIf.sv ====
`timescale 1ns/1ps

interface fifoWriteIf import readbackPkg::*; ();

	logic [WORD_W-1:0]     wrData;
	logic                  wrEn;

	// Fill status returned by the FIFO
	logic                  almostFull;
	logic [FIFO_CNT_W-1:0] count;

	modport packer
	(
		output wrData,
		output wrEn,
		input  almostFull
	);

	modport fifo
	(
		input  wrData,
		input  wrEn,
		output almostFull,
		output count
	);

endinterface

// ==== source/pixelPacker.sv ====
`timescale 1ns/1ps

module pixelPacker import readbackPkg::*;
(
	input  logic       i_clk,
	input  logic       i_nrst,

	input  logic       i_pixValid,
	input  logic [7:0] i_r,
	input  logic [7:0] i_g,
	input  logic [7:0] i_b,

	input  ctrlReg_t   i_ctrl,
	input  logic       i_ctrlWrite,

	fifoWriteIf.packer wr,
	output logic       o_stopFill
);

	logic [2:0]        phase;
	logic              wordStb;
	logic              selStage1;

	// Stage1 only holds the middle word of a 24-bit group
	logic [WORD_W-1:0] stage0;
	logic [WORD_W-1:0] stage1;

	// Nibble enables for stage0, byte enables for stage1
	logic [7:0]        en0;
	logic [3:0]        en1;
	logic [WORD_W-1:0] val0;
	logic [WORD_W-1:0] val1;
	logic              wordDone;
	logic              useStage1;
	logic              groupLast;
	logic [15:0]       half15;

	assign half15 = {i_r[7:3], i_g[7:3], i_b[7:3], i_ctrl.setMask};

	always_comb
	begin
		en0       = 8'h00;
		en1       = 4'h0;
		val0      = '0;
		val1      = '0;
		wordDone  = 1'b0;
		useStage1 = 1'b0;
		groupLast = 1'b0;
		case (i_ctrl.format)
			FMT_GREY4:
			begin
				en0       = 8'h80 >> phase;
				val0      = {8{i_r[7:4]}};
				wordDone  = (phase == 3'd7);
				groupLast = wordDone;
			end
			FMT_GREY8:
			begin
				en0       = 8'hC0 >> {phase[1:0], 1'b0};
				val0      = {4{i_r}};
				wordDone  = (phase == 3'd3);
				groupLast = wordDone;
			end
			FMT_RGB15:
			begin
				en0       = phase[0] ? 8'h0F : 8'hF0;
				val0      = {2{half15}};
				wordDone  = (phase == 3'd1);
				groupLast = wordDone;
			end
			FMT_RGB24:
			begin
				// 4 pixels of R,G,B bytes make 3 words
				case (phase[1:0])
					2'd0:
					begin
						en0 = 8'hFC;
						val0 = {i_r, i_g, i_b, 8'h00};
					end
					2'd1:
					begin
						en0 = 8'h03;
						val0 = {24'h0, i_r};
						en1 = 4'hC;
						val1 = {i_g, i_b, 16'h0};
						wordDone = 1'b1;
					end
					2'd2:
					begin
						en0 = 8'hC0;
						val0 = {i_b, 24'h0};
						en1 = 4'h3;
						val1 = {16'h0, i_r, i_g};
						wordDone = 1'b1;
						useStage1 = 1'b1;
					end
					default:
					begin
						en0 = 8'h3F;
						val0 = {8'h0, i_r, i_g, i_b};
						wordDone = 1'b1;
						groupLast = 1'b1;
					end
				endcase
			end
		endcase
	end

	always_ff @(posedge i_clk)
	begin
		if (i_pixValid)
		begin
			for (int k = 0; k < 8; k++)
			begin
				if (en0[k])
					stage0[4*k +: 4] <= val0[4*k +: 4];
			end
			for (int k = 0; k < 4; k++)
			begin
				if (en1[k])
					stage1[8*k +: 8] <= val1[8*k +: 8];
			end
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_nrst)
		begin
			phase     <= 3'd0;
			wordStb   <= 1'b0;
			selStage1 <= 1'b0;
		end
		else
		begin
			// A completed word is still pushed when the format changes
			wordStb   <= i_pixValid && wordDone;
			selStage1 <= useStage1;
			if (i_ctrlWrite)
				phase <= 3'd0;
			else if (i_pixValid)
				phase <= groupLast ? 3'd0 : phase + 3'd1;
		end
	end

	assign wr.wrEn   = wordStb;
	assign wr.wrData = selStage1 ? stage1 : stage0;
	assign o_stopFill = wr.almostFull;

endmodule

// ==== source/syncFifo.sv ====
`timescale 1ns/1ps

module syncFifo import readbackPkg::*;
#(
	parameter type T = logic [WORD_W-1:0]
)
(
	input  logic     i_clk,
	input  logic     i_nrst,

	fifoWriteIf.fifo wr,

	input  logic     i_pop,
	output T         o_data,
	output logic     o_empty
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	T                      mem [FIFO_DEPTH];
	logic [PTR_W-1:0]      wrPtr;
	logic [PTR_W-1:0]      rdPtr;
	logic [FIFO_CNT_W-1:0] count;
	logic                  full;
	logic                  doPush;
	logic                  doPop;

	assign full    = (count == FIFO_CNT_W'(FIFO_DEPTH));
	assign o_empty = (count == '0);
	assign doPush  = wr.wrEn && !full;
	assign doPop   = i_pop && !o_empty;

	always_ff @(posedge i_clk)
	begin
		if (doPush)
			mem[wrPtr] <= T'(wr.wrData);
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_nrst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= (wrPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign o_data = mem[rdPtr];
	assign wr.count = count;

	// Stop while free space is at most the margin
	assign wr.almostFull = (count >= FIFO_CNT_W'(FIFO_DEPTH - FIFO_STOP_MARGIN));

endmodule

// ==== source/cpuRegPort.sv ====
`timescale 1ns/1ps

module cpuRegPort import readbackPkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_nrst,

	// AXI4-Lite write channels
	input  logic [ADDR_W-1:0]     i_awaddr,
	input  logic                  i_awvalid,
	output logic                  o_awready,
	input  logic [WORD_W-1:0]     i_wdata,
	input  logic [3:0]            i_wstrb,
	input  logic                  i_wvalid,
	output logic                  o_wready,
	output logic [1:0]            o_bresp,
	output logic                  o_bvalid,
	input  logic                  i_bready,

	// AXI4-Lite read channels
	input  logic [ADDR_W-1:0]     i_araddr,
	input  logic                  i_arvalid,
	output logic                  o_arready,
	output logic [WORD_W-1:0]     o_rdata,
	output logic [1:0]            o_rresp,
	output logic                  o_rvalid,
	input  logic                  i_rready,

	output ctrlReg_t              o_ctrl,
	output logic                  o_ctrlWrite,

	input  logic [WORD_W-1:0]     i_fifoData,
	input  logic                  i_fifoEmpty,
	input  logic [FIFO_CNT_W-1:0] i_fifoCount,
	output logic                  o_fifoPop
);

	logic              wrAccept;
	logic              rdAccept;
	logic              wrIsCtrl;
	logic [WORD_W-1:0] rdDataNext;
	logic [1:0]        rdRespNext;

	// Address and data are taken in the same cycle
	assign wrAccept  = i_awvalid && i_wvalid && !o_bvalid;
	assign o_awready = wrAccept;
	assign o_wready  = wrAccept;
	assign wrIsCtrl  = (i_awaddr == ADDR_CTRL);

	assign o_ctrlWrite = wrAccept && wrIsCtrl && i_wstrb[0];

	assign o_arready = !o_rvalid;
	assign rdAccept  = i_arvalid && !o_rvalid;

	always_comb
	begin
		rdDataNext = '0;
		rdRespNext = RESP_OKAY;
		o_fifoPop  = 1'b0;
		case (i_araddr)
			ADDR_CTRL:
				rdDataNext = {{(WORD_W - $bits(ctrlReg_t)){1'b0}}, o_ctrl};
			ADDR_STATUS:
				rdDataNext = {23'h0, i_fifoCount, 3'b000, !i_fifoEmpty};
			ADDR_DATA:
			begin
				if (i_fifoEmpty)
					rdRespNext = RESP_SLVERR;
				else
				begin
					rdDataNext = i_fifoData;
					o_fifoPop  = rdAccept;
				end
			end
			default:
				rdRespNext = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_nrst)
		begin
			o_ctrl   <= '0;
			o_bvalid <= 1'b0;
			o_rvalid <= 1'b0;
		end
		else
		begin
			if (o_ctrlWrite)
				o_ctrl <= ctrlReg_t'(i_wdata[$bits(ctrlReg_t)-1:0]);

			if (wrAccept)
				o_bvalid <= 1'b1;
			else if (i_bready)
				o_bvalid <= 1'b0;

			if (rdAccept)
				o_rvalid <= 1'b1;
			else if (i_rready)
				o_rvalid <= 1'b0;
		end
	end

	// Response payloads hold while the master stalls
	always_ff @(posedge i_clk)
	begin
		if (wrAccept)
			o_bresp <= wrIsCtrl ? RESP_OKAY : RESP_SLVERR;
		if (rdAccept)
		begin
			o_rdata <= rdDataNext;
			o_rresp <= rdRespNext;
		end
	end

endmodule

// ==== source/gpuReadback.sv ====
`timescale 1ns/1ps

module gpuReadback import readbackPkg::*;
(
	input  logic              i_clk,
	input  logic              i_nrst,

	// Pixel source
	input  logic              i_pixValid,
	input  logic [7:0]        i_r,
	input  logic [7:0]        i_g,
	input  logic [7:0]        i_b,
	output logic              o_stopFill,

	// CPU side AXI4-Lite slave
	input  logic [ADDR_W-1:0] i_awaddr,
	input  logic              i_awvalid,
	output logic              o_awready,
	input  logic [WORD_W-1:0] i_wdata,
	input  logic [3:0]        i_wstrb,
	input  logic              i_wvalid,
	output logic              o_wready,
	output logic [1:0]        o_bresp,
	output logic              o_bvalid,
	input  logic              i_bready,
	input  logic [ADDR_W-1:0] i_araddr,
	input  logic              i_arvalid,
	output logic              o_arready,
	output logic [WORD_W-1:0] o_rdata,
	output logic [1:0]        o_rresp,
	output logic              o_rvalid,
	input  logic              i_rready
);

	ctrlReg_t          ctrl;
	logic              ctrlWrite;
	logic [WORD_W-1:0] fifoData;
	logic              fifoEmpty;
	logic              fifoPop;

	fifoWriteIf fifoWr();

	pixelPacker packer
	(
		.i_clk       (i_clk),
		.i_nrst      (i_nrst),
		.i_pixValid  (i_pixValid),
		.i_r         (i_r),
		.i_g         (i_g),
		.i_b         (i_b),
		.i_ctrl      (ctrl),
		.i_ctrlWrite (ctrlWrite),
		.wr          (fifoWr.packer),
		.o_stopFill  (o_stopFill)
	);

	syncFifo #(.T(logic [WORD_W-1:0])) fifo
	(
		.i_clk   (i_clk),
		.i_nrst  (i_nrst),
		.wr      (fifoWr.fifo),
		.i_pop   (fifoPop),
		.o_data  (fifoData),
		.o_empty (fifoEmpty)
	);

	cpuRegPort regPort
	(
		.i_clk       (i_clk),
		.i_nrst      (i_nrst),
		.i_awaddr    (i_awaddr),
		.i_awvalid   (i_awvalid),
		.o_awready   (o_awready),
		.i_wdata     (i_wdata),
		.i_wstrb     (i_wstrb),
		.i_wvalid    (i_wvalid),
		.o_wready    (o_wready),
		.o_bresp     (o_bresp),
		.o_bvalid    (o_bvalid),
		.i_bready    (i_bready),
		.i_araddr    (i_araddr),
		.i_arvalid   (i_arvalid),
		.o_arready   (o_arready),
		.o_rdata     (o_rdata),
		.o_rresp     (o_rresp),
		.o_rvalid    (o_rvalid),
		.i_rready    (i_rready),
		.o_ctrl      (ctrl),
		.o_ctrlWrite (ctrlWrite),
		.i_fifoData  (fifoData),
		.i_fifoEmpty (fifoEmpty),
		.i_fifoCount (fifoWr.count),
		.o_fifoPop   (fifoPop)
	);

endmodule

// ==== test/readbackChecker.sv ====
`timescale 1ns/1ps

module readbackChecker import readbackPkg::*;
(
	input  logic              i_clk,
	input  logic              i_nrst,

	// Pixel side
	input  logic              i_pixValid,
	input  logic [7:0]        i_r,
	input  logic [7:0]        i_g,
	input  logic [7:0]        i_b,
	input  logic              i_stopFill,

	// AXI4-Lite as seen on the DUT ports
	input  logic [ADDR_W-1:0] i_awaddr,
	input  logic              i_awvalid,
	input  logic              i_awready,
	input  logic [WORD_W-1:0] i_wdata,
	input  logic [3:0]        i_wstrb,
	input  logic              i_wvalid,
	input  logic              i_wready,
	input  logic [1:0]        i_bresp,
	input  logic              i_bvalid,
	input  logic              i_bready,
	input  logic [ADDR_W-1:0] i_araddr,
	input  logic              i_arvalid,
	input  logic              i_arready,
	input  logic [WORD_W-1:0] i_rdata,
	input  logic [1:0]        i_rresp,
	input  logic              i_rvalid,
	input  logic              i_rready,

	output int                o_checks,
	output int                o_errors
);

	int                checks = 0;
	int                errors = 0;
	logic              prevNrst = 1'b0;
	pixFormat_t        fmt;
	logic              mask;
	logic [23:0]       pixQ [$];
	logic [WORD_W-1:0] expQ [$];
	logic [WORD_W-1:0] expRdata;
	logic [1:0]        expRresp;
	logic [1:0]        expBresp;
	logic              arTaken;
	logic              awTaken;
	logic              rHeld;
	logic [WORD_W-1:0] heldRdata;

	assign o_checks = checks;
	assign o_errors = errors;

	function automatic int groupPixels(input pixFormat_t f);
		case (f)
			FMT_GREY4: return 8;
			FMT_GREY8: return 4;
			FMT_RGB15: return 2;
			default:   return 4;
		endcase
	endfunction

	function automatic int groupWords(input pixFormat_t f);
		return (f == FMT_RGB24) ? 3 : 1;
	endfunction

	// Word idx of a complete group with the first pixel in the top bits
	function automatic logic [WORD_W-1:0] packWord(input pixFormat_t f, input logic m,
		input logic [23:0] pix [8], input int idx);
		logic [WORD_W-1:0] w;
		logic [7:0]        stream [12];
		w = '0;
		case (f)
			FMT_GREY4:
				for (int k = 0; k < 8; k++)
					w[31-4*k -: 4] = pix[k][23:20];
			FMT_GREY8:
				for (int k = 0; k < 4; k++)
					w[31-8*k -: 8] = pix[k][23:16];
			FMT_RGB15:
				for (int k = 0; k < 2; k++)
					w[31-16*k -: 16] = {pix[k][23:19], pix[k][15:11], pix[k][7:3], m};
			default:
			begin
				// R, G, B byte stream cut into words
				for (int k = 0; k < 4; k++)
				begin
					stream[3*k]     = pix[k][23:16];
					stream[3*k + 1] = pix[k][15:8];
					stream[3*k + 2] = pix[k][7:0];
				end
				for (int k = 0; k < 4; k++)
					w[31-8*k -: 8] = stream[4*idx + k];
			end
		endcase
		return w;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			$display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic acceptPixel(input logic [23:0] pix);
		logic [23:0] grp [8];
		pixQ.push_back(pix);
		if (pixQ.size() == groupPixels(fmt))
		begin
			for (int k = 0; k < 8; k++)
				grp[k] = (k < pixQ.size()) ? pixQ[k] : 24'h0;
			for (int w = 0; w < groupWords(fmt); w++)
				expQ.push_back(packWord(fmt, mask, grp, w));
			pixQ.delete();
		end
	endtask

	task automatic acceptWrite(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
		input logic [3:0] strb);
		expBresp = (addr == ADDR_CTRL) ? RESP_OKAY : RESP_SLVERR;
		if (addr == ADDR_CTRL && strb[0])
		begin
			fmt  = pixFormat_t'(data[2:1]);
			mask = data[0];
			// Partial group is lost
			pixQ.delete();
		end
	endtask

	// Expected read response where a data read pops the model queue
	task automatic predictRead(input logic [ADDR_W-1:0] addr);
		int cnt;
		cnt      = expQ.size();
		expRresp = RESP_OKAY;
		expRdata = '0;
		// Stop is raised while the free space is at most the margin
		checkValue("o_stopFill", (FIFO_DEPTH - cnt) <= FIFO_STOP_MARGIN, i_stopFill);
		case (addr)
			ADDR_CTRL:
				expRdata = {29'h0, fmt, mask};
			ADDR_STATUS:
				expRdata = {23'h0, cnt[4:0], 3'b000, (cnt != 0)};
			ADDR_DATA:
			begin
				if (cnt == 0)
					expRresp = RESP_SLVERR;
				else
					expRdata = expQ.pop_front();
			end
			default:
				expRresp = RESP_SLVERR;
		endcase
	endtask

	always @(posedge i_clk)
	begin
		if (!i_nrst)
		begin
			fmt     = FMT_GREY4;
			mask    = 1'b0;
			arTaken = 1'b0;
			awTaken = 1'b0;
			rHeld   = 1'b0;
			pixQ.delete();
			expQ.delete();
		end
		else
		begin
			if (!prevNrst)
			begin
				checkValue("o_rvalid", 0, i_rvalid);
				checkValue("o_bvalid", 0, i_bvalid);
				checkValue("o_stopFill", 0, i_stopFill);
			end
			// Responses rise one cycle after acceptance
			if (arTaken)
				checkValue("o_rvalid", 1, i_rvalid);
			if (awTaken)
				checkValue("o_bvalid", 1, i_bvalid);
			if (rHeld)
			begin
				checkValue("o_rvalid", 1, i_rvalid);
				checkValue("o_rdata", heldRdata, i_rdata);
			end
			if (i_rvalid)
				checkValue("o_arready", 0, i_arready);
			if (i_rvalid && i_rready)
			begin
				checkValue("o_rdata", expRdata, i_rdata);
				checkValue("o_rresp", expRresp, i_rresp);
			end
			if (i_bvalid && i_bready)
				checkValue("o_bresp", expBresp, i_bresp);
			if (!i_bvalid && i_awvalid && i_wvalid)
			begin
				// An idle slave takes address and data together
				checkValue("o_awready", 1, i_awready);
				checkValue("o_wready", 1, i_wready);
			end

			arTaken = i_arvalid && i_arready;
			if (arTaken)
				predictRead(i_araddr);
			if (i_pixValid)
				acceptPixel({i_r, i_g, i_b});
			awTaken = i_awvalid && i_awready && i_wvalid && i_wready;
			if (awTaken)
				acceptWrite(i_awaddr, i_wdata, i_wstrb);

			rHeld     = i_rvalid && !i_rready;
			heldRdata = i_rdata;
		end
		prevNrst = i_nrst;
	end

endmodule

// ==== test/tbGpuReadback.sv ====
`timescale 1ns/1ps

module tbGpuReadback import readbackPkg::*;
();

	localparam int CLK_PERIOD   = 20;
	localparam int FILL_PIX_MAX = 64;

	// Pixels and AXI accesses of phases 1 to 6
	localparam int PIX_TOTAL   = 0 + 64 + 8 + (FILL_PIX_MAX + 2) + 13 + 4;
	localparam int AXI_TOTAL   = 3 + 28 + 9 + 19 + 6 + 7;
	localparam int CYCLE_LIMIT = 20 * PIX_TOTAL + 40 * AXI_TOTAL;

	logic              clk;
	logic              nrst;
	logic              pixValid;
	logic [7:0]        r;
	logic [7:0]        g;
	logic [7:0]        b;
	logic              stopFill;
	logic [ADDR_W-1:0] awaddr;
	logic              awvalid;
	logic              awready;
	logic [WORD_W-1:0] wdata;
	logic [3:0]        wstrb;
	logic              wvalid;
	logic              wready;
	logic [1:0]        bresp;
	logic              bvalid;
	logic              bready;
	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic [WORD_W-1:0] rdata;
	logic [1:0]        rresp;
	logic              rvalid;
	logic              rready;

	logic [31:0]       lfsrState;
	logic [WORD_W-1:0] readData;
	int                cycleCount;
	int                tbErrors;
	int                checks;
	int                errors;

	gpuReadback DUT
	(
		.i_clk(clk), .i_nrst(nrst),
		.i_pixValid(pixValid), .i_r(r), .i_g(g), .i_b(b), .o_stopFill(stopFill),
		.i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
		.i_wdata(wdata), .i_wstrb(wstrb), .i_wvalid(wvalid), .o_wready(wready),
		.o_bresp(bresp), .o_bvalid(bvalid), .i_bready(bready),
		.i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
		.o_rdata(rdata), .o_rresp(rresp), .o_rvalid(rvalid), .i_rready(rready)
	);

	readbackChecker scoreboard
	(
		.i_clk(clk), .i_nrst(nrst),
		.i_pixValid(pixValid), .i_r(r), .i_g(g), .i_b(b), .i_stopFill(stopFill),
		.i_awaddr(awaddr), .i_awvalid(awvalid), .i_awready(awready),
		.i_wdata(wdata), .i_wstrb(wstrb), .i_wvalid(wvalid), .i_wready(wready),
		.i_bresp(bresp), .i_bvalid(bvalid), .i_bready(bready),
		.i_araddr(araddr), .i_arvalid(arvalid), .i_arready(arready),
		.i_rdata(rdata), .i_rresp(rresp), .i_rvalid(rvalid), .i_rready(rready),
		.o_checks(checks), .o_errors(errors)
	);

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic randomByte(output logic [7:0] v);
		v = '0;
		for (int k = 0; k < 8; k++)
		begin
			v = {v[6:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	task automatic drivePixel();
		randomByte(r);
		randomByte(g);
		randomByte(b);
		pixValid = 1'b1;
	endtask

	// Back to back pixels, then time for the last word to land
	task automatic sendPixels(input int n);
		repeat (n)
		begin
			@(negedge clk);
			drivePixel();
		end
		@(negedge clk);
		pixValid = 1'b0;
		repeat (4) @(negedge clk);
	endtask

	task automatic axiWrite(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
		@(negedge clk);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hF;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		while (bvalid) @(negedge clk);
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid) @(negedge clk);
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axiRead(input logic [ADDR_W-1:0] addr, input int hold,
		output logic [WORD_W-1:0] data);
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		rready  = 1'b0;
		while (!arready) @(negedge clk);
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid) @(negedge clk);
		repeat (hold) @(negedge clk);
		data   = rdata;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic setFormat(input pixFormat_t f, input logic m);
		axiWrite(ADDR_CTRL, {29'h0, f, m});
	endtask

	// Read the fill count, pop that many words, repeat until empty
	task automatic drainFifo();
		logic [WORD_W-1:0] data;
		int                pending;
		int                rounds;
		pending = 1;
		rounds  = 0;
		while (pending != 0 && rounds < 4)
		begin
			axiRead(ADDR_STATUS, 0, data);
			pending = int'(data[8:4]);
			repeat (pending) axiRead(ADDR_DATA, 0, data);
			rounds++;
		end
	endtask

	task automatic runFormat(input pixFormat_t f, input logic m, input int n);
		setFormat(f, m);
		sendPixels(n);
		drainFifo();
	endtask

	// Source keeps strobing until stop, then delivers two more pixels
	task automatic fillUntilStop();
		int sent;
		sent = 0;
		@(negedge clk);
		while (!stopFill && sent < FILL_PIX_MAX)
		begin
			drivePixel();
			sent++;
			@(negedge clk);
		end
		if (!stopFill)
		begin
			$display("ERROR: o_stopFill did not rise after %0d pixels", sent);
			tbErrors++;
		end
		else
		begin
			repeat (2)
			begin
				drivePixel();
				sent++;
				@(negedge clk);
			end
		end
		pixValid = 1'b0;
		repeat (4) @(negedge clk);
	endtask

	task automatic reportAndFinish();
		$display("Summary: %0d checks, %0d checker errors, %0d testbench errors",
			checks, errors, tbErrors);
		if (errors == 0 && tbErrors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("ERROR: run stopped by the timeout after %0d cycles", cycleCount);
		tbErrors++;
		reportAndFinish();
	end

	initial
	begin
		nrst      = 1'b0;
		pixValid  = 1'b0;
		r         = '0;
		g         = '0;
		b         = '0;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		tbErrors  = 0;
		lfsrState = 32'h4b47;
		repeat (5) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;

		// Reset values and an empty data read
		axiRead(ADDR_STATUS, 0, readData);
		axiRead(ADDR_CTRL, 0, readData);
		axiRead(ADDR_DATA, 0, readData);

		runFormat(FMT_GREY4, 1'b0, 32);
		runFormat(FMT_GREY8, 1'b0, 16);
		runFormat(FMT_RGB15, 1'b0, 8);
		runFormat(FMT_RGB15, 1'b1, 8);
		runFormat(FMT_RGB24, 1'b0, 8);

		// Fill in the densest format against the stop signal
		setFormat(FMT_RGB24, 1'b0);
		fillUntilStop();
		drainFifo();

		// Format change halfway through a GREY4 word
		setFormat(FMT_GREY4, 1'b0);
		sendPixels(5);
		setFormat(FMT_GREY8, 1'b0);
		sendPixels(8);
		drainFifo();

		// Stalled read data, then bad addresses
		setFormat(FMT_RGB15, 1'b0);
		sendPixels(4);
		axiRead(ADDR_DATA, 6, readData);
		drainFifo();
		axiRead(4'hC, 0, readData);
		axiWrite(ADDR_STATUS, 32'h0);

		repeat (5) @(negedge clk);
		reportAndFinish();
	end

endmodule

// ==== tb.f ====
source/readbackPkg.sv
source/fifoWriteIf.sv
source/pixelPacker.sv
source/syncFifo.sv
source/cpuRegPort.sv
source/gpuReadback.sv
test/readbackChecker.sv
test/tbGpuReadback.sv

// ==== Makefile ====
TOOL    = verilator
FLAGS   = --binary --timing -Wno-fatal -j 0
TOP     = tbGpuReadback
FILES   = tb.f
OUTDIR  = obj_dir
PASSMSG = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILES) -Mdir $(OUTDIR)
	@out="$$(./$(OUTDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSMSG)"

clean:
	rm -rf $(OUTDIR)
